//--- logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] uint_x;
    typedef logic [xlen-1:0] addr_t;

    // access kind seen by the stage
    typedef enum logic [1:0] {
        op_none,
        op_load,
        op_store,
        op_atomic
    } mem_op_e;

    // also used as the write mask code on the bus
    typedef enum logic [1:0] {
        size_b,
        size_h,
        size_w
    } mem_size_e;

    typedef enum logic {
        sign_signed,
        sign_unsigned
    } sign_sel_e;

    typedef enum logic [3:0] {
        amo_lr,
        amo_sc,
        amo_swap,
        amo_add,
        amo_xor,
        amo_and,
        amo_or,
        amo_min,
        amo_max
    } amo_sel_e;

    typedef enum logic {
        fault_access,
        fault_page
    } fault_e;

    // store and amo share a trap cause
    localparam logic [3:0] cause_load_access  = 4'd5;
    localparam logic [3:0] cause_store_access = 4'd7;
    localparam logic [3:0] cause_load_page    = 4'd13;
    localparam logic [3:0] cause_store_page   = 4'd15;

    localparam addr_t no_reservation = '1;   // empty reservation

    // memory geometry
    localparam int    ram_words   = 1024;
    localparam int    ram_idx_w   = $clog2(ram_words);
    localparam addr_t ram_bytes   = addr_t'(ram_words * (xlen / 8));
    localparam int    ram_latency = 2;       // accept to response
    localparam int    ram_cnt_w   = $clog2(ram_latency + 1);

    localparam addr_t page_fault_base = 32'hffff_f000;

endpackage

`default_nettype wire

//--- logic/dcache_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dcache_if import mem_pkg::*; ();

    // request channel
    logic      req_valid;
    logic      wen;
    addr_t     addr;
    uint_x     wdata;
    mem_size_e wmask;      // size code picks the byte lanes

    // response channel
    logic      ready;
    logic      resp_valid;
    uint_x     rdata;      // addressed data in the low bits
    logic      error;
    fault_e    errty;

    modport requester (
        output req_valid, wen, addr, wdata, wmask,
        input  ready, resp_valid, rdata, error, errty
    );

    modport responder (
        input  req_valid, wen, addr, wdata, wmask,
        output ready, resp_valid, rdata, error, errty
    );

endinterface

`default_nettype wire

//--- logic/amo_alu.sv
`timescale 1ns/1ps
`default_nettype none

module amo_alu import mem_pkg::*; (
    input  wire amo_sel_e  amo_sel,
    input  wire sign_sel_e sign,
    input  wire uint_x     mem_word,
    input  wire uint_x     operand,
    output uint_x          result
);

    logic less;   // mem_word below operand

    always_comb begin
        if (sign == sign_signed) begin
            less = $signed(mem_word) < $signed(operand);
        end else begin
            less = mem_word < operand;
        end
    end

    always_comb begin
        case (amo_sel)
            amo_add: result = mem_word + operand;
            amo_xor: result = mem_word ^ operand;
            amo_and: result = mem_word & operand;
            amo_or:  result = mem_word | operand;
            amo_min: result = less ? mem_word : operand;
            amo_max: result = less ? operand : mem_word;
            // swap and sc write rs2 unchanged
            default: result = operand;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align import mem_pkg::*; (
    input  wire mem_op_e   op,
    input  wire amo_sel_e  amo_sel,
    input  wire mem_size_e size,
    input  wire sign_sel_e sign,
    input  wire uint_x     raw,
    input  wire            sc_ok,
    output uint_x          result
);

    logic sext;

    assign sext = sign == sign_signed;

    always_comb begin
        if (op == op_atomic) begin
            if (amo_sel == amo_sc) begin
                result = sc_ok ? '0 : uint_x'(1);   // 0 means success
            end else begin
                result = raw;   // lr and amo hand back the old word
            end
        end else begin
            case (size)
                size_b: begin
                    if (sext) begin
                        result = {{(xlen - 8){raw[7]}}, raw[7:0]};
                    end else begin
                        result = {{(xlen - 8){1'b0}}, raw[7:0]};
                    end
                end
                size_h: begin
                    if (sext) begin
                        result = {{(xlen - 16){raw[15]}}, raw[15:0]};
                    end else begin
                        result = {{(xlen - 16){1'b0}}, raw[15:0]};
                    end
                end
                default: result = raw;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage import mem_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            valid,
    input  wire            is_new,
    input  wire mem_op_e   op,
    input  wire amo_sel_e  amo_sel,
    input  wire mem_size_e size,
    input  wire sign_sel_e sign,
    input  wire addr_t     addr,
    input  wire uint_x     wdata,
    input  wire            trap_in_valid,
    input  wire [3:0]      trap_in_cause,
    dcache_if.requester    dmem,
    output logic           stall,
    output uint_x          rdata,
    output logic           trap_valid,
    output logic [3:0]     trap_cause
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ready,
        st_wait_read,
        st_wait_write
    } state_e;

    state_e state_q;
    logic   executed_q;
    logic   store_pass_q;    // amo second pass runs as a store
    logic   err_q;
    addr_t  reservation_q;
    logic   sc_ok_q;
    fault_e errty_q;
    uint_x  saved_rdata_q;
    uint_x  amo_wdata;

    logic done;
    logic is_lr;
    logic is_sc;
    logic is_rmw;
    logic sc_match;
    logic req_wen;
    logic store_cause;

    assign done     = executed_q && !is_new;   // is_new opens a fresh instruction
    assign is_lr    = op == op_atomic && amo_sel == amo_lr;
    assign is_sc    = op == op_atomic && amo_sel == amo_sc;
    assign is_rmw   = op == op_atomic && !is_lr && !is_sc;
    assign sc_match = reservation_q == addr;
    assign req_wen  = store_pass_q || op == op_store || is_sc;

    assign stall = valid && op != op_none && (state_q != st_idle || !done);

    assign dmem.req_valid = state_q == st_wait_ready;
    assign dmem.wen       = req_wen;
    assign dmem.addr      = addr;
    assign dmem.wdata     = op == op_atomic ? amo_wdata : wdata;
    assign dmem.wmask     = size;

    amo_alu i_amo_alu (
        .amo_sel  (amo_sel),
        .sign     (sign),
        .mem_word (saved_rdata_q),
        .operand  (wdata),
        .result   (amo_wdata)
    );

    load_align i_load_align (
        .op      (op),
        .amo_sel (amo_sel),
        .size    (size),
        .sign    (sign),
        .raw     (saved_rdata_q),
        .sc_ok   (sc_ok_q),
        .result  (rdata)
    );

    // only lr counts as a load among the atomics
    assign store_cause = !(op == op_load || is_lr);

    always_comb begin
        if (op == op_none) begin
            trap_valid = trap_in_valid;
            trap_cause = trap_in_cause;
        end else begin
            trap_valid = err_q;
            if (!err_q) begin
                trap_cause = '0;
            end else if (errty_q == fault_access) begin
                trap_cause = store_cause ? cause_store_access : cause_load_access;
            end else begin
                trap_cause = store_cause ? cause_store_page : cause_load_page;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= st_idle;
            executed_q    <= 1'b0;
            store_pass_q  <= 1'b0;
            err_q         <= 1'b0;
            reservation_q <= no_reservation;
        end else if (!valid || op == op_none) begin
            state_q      <= st_idle;
            executed_q   <= 1'b0;
            store_pass_q <= 1'b0;
        end else begin
            if (is_new) begin
                executed_q <= 1'b0;
            end
            case (state_q)
                st_idle: begin
                    if (!done) begin
                        state_q <= st_wait_ready;
                        err_q   <= 1'b0;
                        if (is_lr) begin
                            reservation_q <= addr;
                        end
                        if (is_sc) begin
                            reservation_q <= no_reservation;   // dropped either way
                            if (!sc_match) begin
                                state_q    <= st_idle;         // fails without a request
                                executed_q <= 1'b1;
                            end
                        end
                    end
                end
                st_wait_ready: begin
                    if (dmem.ready) begin
                        state_q <= req_wen ? st_wait_write : st_wait_read;
                    end
                end
                st_wait_read: begin
                    if (dmem.resp_valid) begin
                        err_q <= dmem.error;
                        if (is_rmw && !dmem.error) begin
                            state_q      <= st_wait_ready;
                            store_pass_q <= 1'b1;
                        end else begin
                            state_q    <= st_idle;
                            executed_q <= 1'b1;
                        end
                    end
                end
                default: begin
                    if (dmem.resp_valid) begin
                        err_q        <= dmem.error;
                        state_q      <= st_idle;
                        executed_q   <= 1'b1;
                        store_pass_q <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle && !done && is_sc) begin
            sc_ok_q <= sc_match;
        end
        if (dmem.resp_valid) begin
            errty_q <= dmem.errty;
            if (state_q == st_wait_read) begin
                saved_rdata_q <= dmem.rdata;   // keep the old word across the store pass
            end
        end
    end

    // held request must not change under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        dmem.req_valid && !dmem.ready |=>
            $stable({dmem.wen, dmem.addr, dmem.wdata, dmem.wmask}));

    assert property (@(posedge clk) disable iff (rst)
        dmem.req_valid |-> op != op_none);

    // memory answers only an access that is outstanding
    assert property (@(posedge clk) disable iff (rst)
        dmem.resp_valid |-> state_q inside {st_wait_read, st_wait_write});

endmodule

`default_nettype wire

//--- logic/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram import mem_pkg::*; (
    input wire          clk,
    input wire          rst,
    dcache_if.responder dmem
);

    uint_x                mem_q [ram_words];
    logic                 busy_q;
    logic [ram_cnt_w-1:0] cnt_q;
    uint_x                rdata_q;
    logic                 err_q;
    fault_e               errty_q;

    logic                 accept;
    logic                 page_hit;
    logic                 access_hit;
    logic [ram_idx_w-1:0] idx;
    logic [1:0]           offset;
    logic [xlen/8-1:0]    lane_base;
    logic [xlen/8-1:0]    lanes;
    uint_x                wdata_sh;

    assign accept     = dmem.req_valid && dmem.ready;
    assign page_hit   = dmem.addr >= page_fault_base;
    assign access_hit = !page_hit && dmem.addr >= ram_bytes;
    assign idx        = dmem.addr[ram_idx_w+1:2];   // word index
    assign offset     = dmem.addr[1:0];
    assign wdata_sh   = dmem.wdata << {offset, 3'b000};

    always_comb begin
        case (dmem.wmask)
            size_b:  lane_base = 4'b0001;
            size_h:  lane_base = 4'b0011;
            default: lane_base = 4'b1111;
        endcase
    end

    assign lanes = lane_base << offset;

    assign dmem.ready      = !busy_q;
    assign dmem.resp_valid = busy_q && cnt_q == '0;
    assign dmem.rdata      = rdata_q;
    assign dmem.error      = err_q;
    assign dmem.errty      = errty_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            cnt_q  <= ram_cnt_w'(ram_latency - 1);
        end else if (busy_q) begin
            if (cnt_q == '0) begin
                busy_q <= 1'b0;   // response leaves this cycle
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // a faulting access is decided at acceptance and writes nothing
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= mem_q[idx] >> {offset, 3'b000};
            err_q   <= page_hit || access_hit;
            errty_q <= page_hit ? fault_page : fault_access;
            if (dmem.wen && !page_hit && !access_hit) begin
                for (int b = 0; b < xlen / 8; b++) begin
                    if (lanes[b]) begin
                        mem_q[idx][b*8 +: 8] <= wdata_sh[b*8 +: 8];
                    end
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        accept |=> !accept [*ram_latency]);

endmodule

`default_nettype wire

//--- logic/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top import mem_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            valid,
    input  wire            is_new,
    input  wire mem_op_e   op,
    input  wire amo_sel_e  amo_sel,
    input  wire mem_size_e size,
    input  wire sign_sel_e sign,
    input  wire addr_t     addr,
    input  wire uint_x     wdata,
    input  wire            trap_in_valid,
    input  wire [3:0]      trap_in_cause,
    output wire            stall,
    output wire uint_x     rdata,
    output wire            trap_valid,
    output wire [3:0]      trap_cause
);

    dcache_if dmem ();

    mem_stage i_mem_stage (
        .clk           (clk),
        .rst           (rst),
        .valid         (valid),
        .is_new        (is_new),
        .op            (op),
        .amo_sel       (amo_sel),
        .size          (size),
        .sign          (sign),
        .addr          (addr),
        .wdata         (wdata),
        .trap_in_valid (trap_in_valid),
        .trap_in_cause (trap_in_cause),
        .dmem          (dmem.requester),
        .stall         (stall),
        .rdata         (rdata),
        .trap_valid    (trap_valid),
        .trap_cause    (trap_cause)
    );

    data_ram i_data_ram (
        .clk  (clk),
        .rst  (rst),
        .dmem (dmem.responder)
    );

endmodule

`default_nettype wire

//--- verif/mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb import mem_pkg::*; ();

    localparam int          num_tests       = 5;
    localparam int          cycles_per_test = 200;
    localparam int          op_limit        = 50;   // cycles one access may stall
    localparam int unsigned rng_seed        = 32'hdf4f_4b14;
    localparam int          mem_bytes       = ram_words * (xlen / 8);
    localparam int          bidx_w          = $clog2(mem_bytes);
    localparam addr_t       region_base     = 32'h0000_0100;
    localparam addr_t       amo_base        = 32'h0000_0200;

    logic       clk;
    logic       rst;
    logic       valid;
    logic       is_new;
    mem_op_e    op;
    amo_sel_e   amo_sel;
    mem_size_e  size;
    sign_sel_e  sign;
    addr_t      addr;
    uint_x      wdata;
    logic       trap_in_valid;
    logic [3:0] trap_in_cause;
    logic       stall;
    uint_x      rdata;
    logic       trap_valid;
    logic [3:0] trap_cause;

    logic [7:0] shadow [mem_bytes];   // byte image of data_ram
    uint_x      res_data;
    logic       res_trap;
    logic [3:0] res_cause;

    mem_subsys_top i_mem_subsys_top (
        .clk           (clk),
        .rst           (rst),
        .valid         (valid),
        .is_new        (is_new),
        .op            (op),
        .amo_sel       (amo_sel),
        .size          (size),
        .sign          (sign),
        .addr          (addr),
        .wdata         (wdata),
        .trap_in_valid (trap_in_valid),
        .trap_in_cause (trap_in_cause),
        .stall         (stall),
        .rdata         (rdata),
        .trap_valid    (trap_valid),
        .trap_cause    (trap_cause)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input uint_x got, input uint_x exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic void write_shadow(input addr_t a, input uint_x d, input mem_size_e s);
        int    n;
        addr_t p;
        n = (s == size_b) ? 1 : (s == size_h) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            p = a + addr_t'(i);
            shadow[p[bidx_w-1:0]] = d[8*i +: 8];
        end
    endfunction

    // lowest address lands in the low byte
    function automatic uint_x shadow_word(input addr_t a);
        uint_x w;
        addr_t p;
        for (int i = 0; i < 4; i++) begin
            p = a + addr_t'(i);
            w[8*i +: 8] = shadow[p[bidx_w-1:0]];
        end
        return w;
    endfunction

    function automatic uint_x load_model(input addr_t a, input mem_size_e s,
                                         input sign_sel_e sg);
        uint_x w;
        w = shadow_word(a);
        case (s)
            size_b:  return sg == sign_signed ? {{24{w[7]}}, w[7:0]} : {24'h0, w[7:0]};
            size_h:  return sg == sign_signed ? {{16{w[15]}}, w[15:0]} : {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic uint_x amo_model(input amo_sel_e k, input sign_sel_e sg,
                                        input uint_x m, input uint_x r);
        uint_x bias;
        bias = (sg == sign_signed) ? 32'h8000_0000 : 32'h0;   // signed order as offset binary
        case (k)
            amo_add: return m + r;
            amo_xor: return m ^ r;
            amo_and: return m & r;
            amo_or:  return m | r;
            amo_min: return ((m ^ bias) > (r ^ bias)) ? r : m;
            amo_max: return ((m ^ bias) > (r ^ bias)) ? m : r;
            default: return r;   // swap
        endcase
    endfunction

    task automatic apply_reset();
        rst = 1'b1;
        valid = 1'b0;
        is_new = 1'b0;
        op = op_none;
        trap_in_valid = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    // drive one instruction, wait for stall to drop, keep the outputs
    task automatic issue_op(input mem_op_e o, input amo_sel_e k, input mem_size_e s,
                            input sign_sel_e sg, input addr_t a, input uint_x d);
        int waited;
        waited = 0;
        op = o;
        amo_sel = k;
        size = s;
        sign = sg;
        addr = a;
        wdata = d;
        valid = 1'b1;
        is_new = 1'b1;
        @(negedge clk);
        while (stall) begin
            if (waited == op_limit) begin
                $display("stall stayed high for %0d cycles at address 0x%08h", op_limit, a);
                abort_run();
            end
            waited++;
            @(posedge clk);
            #1;
            is_new = 1'b0;
            @(negedge clk);
        end
        res_data = rdata;
        res_trap = trap_valid;
        res_cause = trap_cause;
        @(posedge clk);
        #1;
        is_new = 1'b0;
    endtask

    task automatic no_trap();
        check_value("trap_valid", uint_x'(res_trap), '0);
    endtask

    task automatic store_data(input addr_t a, input uint_x d, input mem_size_e s);
        issue_op(op_store, amo_lr, s, sign_unsigned, a, d);
        no_trap();
        write_shadow(a, d, s);
    endtask

    task automatic load_and_compare(input addr_t a, input mem_size_e s, input sign_sel_e sg);
        issue_op(op_load, amo_lr, s, sg, a, '0);
        no_trap();
        check_value("rdata", res_data, load_model(a, s, sg));
    endtask

    task automatic stores_then_loads();
        addr_t     a;
        mem_size_e s;
        for (int i = 0; i < 8; i++) begin
            store_data(region_base + addr_t'(4 * i), $urandom(), size_w);
        end
        for (int i = 0; i < 8; i++) begin
            if (i % 2 == 0) begin
                store_data(region_base + addr_t'($urandom_range(31, 0)), $urandom(), size_b);
            end else begin
                store_data(region_base + addr_t'(2 * $urandom_range(15, 0)), $urandom(), size_h);
            end
        end
        for (int i = 0; i < 12; i++) begin
            s = mem_size_e'(i % 3);
            a = region_base + addr_t'(4 * $urandom_range(7, 0));
            case (s)
                size_b:  a = a + addr_t'($urandom_range(3, 0));
                size_h:  a = a + addr_t'(2 * $urandom_range(1, 0));
                default: ;
            endcase
            load_and_compare(a, s, sign_sel_e'((i / 3) % 2));
        end
    endtask

    task automatic amo_round(input amo_sel_e k, input sign_sel_e sg, input uint_x init,
                             input uint_x opnd);
        addr_t a;
        a = amo_base + addr_t'(4 * $urandom_range(7, 0));
        store_data(a, init, size_w);
        issue_op(op_atomic, k, size_w, sg, a, opnd);
        no_trap();
        check_value("rdata", res_data, init);   // old word comes back
        write_shadow(a, amo_model(k, sg, init, opnd), size_w);
        load_and_compare(a, size_w, sign_unsigned);
    endtask

    task automatic amo_ops();
        amo_round(amo_swap, sign_signed, $urandom(), $urandom());
        amo_round(amo_add, sign_signed, $urandom(), $urandom());
        amo_round(amo_xor, sign_signed, $urandom(), $urandom());
        amo_round(amo_and, sign_signed, $urandom(), $urandom());
        amo_round(amo_or, sign_signed, $urandom(), $urandom());
        for (int sg = 0; sg < 2; sg++) begin
            amo_round(amo_min, sign_sel_e'(sg), $urandom(), $urandom());
            amo_round(amo_max, sign_sel_e'(sg), $urandom(), $urandom());
            // operands that order differently signed and unsigned
            amo_round(amo_min, sign_sel_e'(sg), 32'h8000_0000, 32'h7fff_ffff);
            amo_round(amo_max, sign_sel_e'(sg), 32'hffff_ffff, 32'h0000_0001);
        end
    endtask

    task automatic lr_sc_pair();
        addr_t a;
        addr_t b;
        uint_x d;
        a = amo_base + 32'h40;
        b = a + 32'h8;
        store_data(a, $urandom(), size_w);
        store_data(b, $urandom(), size_w);
        issue_op(op_atomic, amo_lr, size_w, sign_signed, a, '0);
        no_trap();
        check_value("rdata", res_data, shadow_word(a));
        d = $urandom();
        issue_op(op_atomic, amo_sc, size_w, sign_signed, a, d);
        no_trap();
        check_value("rdata", res_data, '0);
        write_shadow(a, d, size_w);
        load_and_compare(a, size_w, sign_unsigned);
        issue_op(op_atomic, amo_sc, size_w, sign_signed, a, ~d);   // reservation is gone
        check_value("rdata", res_data, 32'h1);
        load_and_compare(a, size_w, sign_unsigned);
        issue_op(op_atomic, amo_lr, size_w, sign_signed, a, '0);
        issue_op(op_atomic, amo_sc, size_w, sign_signed, b, d);
        check_value("rdata", res_data, 32'h1);
        load_and_compare(b, size_w, sign_unsigned);
    endtask

    task automatic fault_causes();
        // word 0 shares its index with every faulting address below
        store_data(32'h0, $urandom(), size_w);
        issue_op(op_load, amo_lr, size_w, sign_unsigned, ram_bytes, '0);
        check_value("trap_valid", uint_x'(res_trap), 32'h1);
        check_value("trap_cause", uint_x'(res_cause), uint_x'(cause_load_access));
        issue_op(op_store, amo_lr, size_w, sign_unsigned, ram_bytes + 32'h1000, $urandom());
        check_value("trap_valid", uint_x'(res_trap), 32'h1);
        check_value("trap_cause", uint_x'(res_cause), uint_x'(cause_store_access));
        issue_op(op_atomic, amo_add, size_w, sign_signed, page_fault_base, $urandom());
        check_value("trap_valid", uint_x'(res_trap), 32'h1);
        check_value("trap_cause", uint_x'(res_cause), uint_x'(cause_store_page));
        issue_op(op_load, amo_lr, size_w, sign_unsigned, page_fault_base, '0);
        check_value("trap_valid", uint_x'(res_trap), 32'h1);
        check_value("trap_cause", uint_x'(res_cause), uint_x'(cause_load_page));
        load_and_compare(32'h0, size_w, sign_unsigned);
    endtask

    task automatic trap_passthrough();
        apply_reset();
        @(negedge clk);
        check_value("stall", uint_x'(stall), '0);
        @(posedge clk);
        #1;
        for (int i = 0; i < 4; i++) begin
            op = op_none;
            addr = addr_t'($urandom());
            trap_in_valid = (i % 2 == 0);
            trap_in_cause = 4'($urandom());
            valid = 1'b1;
            is_new = 1'b1;
            repeat (2) begin
                @(negedge clk);
                check_value("stall", uint_x'(stall), '0);
                check_value("trap_valid", uint_x'(trap_valid), uint_x'(trap_in_valid));
                check_value("trap_cause", uint_x'(trap_cause), uint_x'(trap_in_cause));
                @(posedge clk);
                #1;
                is_new = 1'b0;
            end
        end
        valid = 1'b0;
        trap_in_valid = 1'b0;
    endtask

    initial begin
        repeat (num_tests * cycles_per_test) @(posedge clk);
        $display("watchdog expired after %0d cycles", num_tests * cycles_per_test);
        abort_run();
    end

    initial begin
        void'($urandom(rng_seed));
        clk = 1'b0;
        rst = 1'b1;
        valid = 1'b0;
        is_new = 1'b0;
        op = op_none;
        amo_sel = amo_lr;
        size = size_w;
        sign = sign_signed;
        addr = '0;
        wdata = '0;
        trap_in_valid = 1'b0;
        trap_in_cause = '0;
        apply_reset();
        stores_then_loads();
        amo_ops();
        lr_sc_pair();
        fault_causes();
        trap_passthrough();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
logic/mem_pkg.sv
logic/dcache_if.sv
logic/amo_alu.sv
logic/load_align.sv
logic/mem_stage.sv
logic/data_ram.sv
logic/mem_subsys_top.sv
verif/mem_subsys_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f tb.f --top-module mem_subsys_tb -o sim_mem_subsys

./obj_dir/sim_mem_subsys > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
    echo "simulation reported an error"
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
echo "simulation finished cleanly"
